//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module tb_soc -f sources.f \
	-o tb_soc_sim || exit 1
out=$(./obj_dir/tb_soc_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Simulation finished: PASS" && echo "run_sim: ok" \
	|| { echo "run_sim: failed"; exit 1; }

//--- sim/tb_soc.sv
module tb_soc;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [63:0] reset_pc = 64'h8000_0000;
	localparam logic [63:0] data_base = 64'hFFFF_FFFF_8000_1000; // lui x5, 0x80001
	localparam int commit_timeout = 200;
	localparam int opc_imm = 'h13;
	localparam int opc_load = 'h03;

	typedef struct packed {
		logic [31:0] instr;
		logic        regwrite;
		logic [4:0]  dst;
		logic [63:0] data;
	} entry_t;

	logic        clk = 1'b0;
	logic        reset;
	logic        mem_req;
	logic        mem_we;
	logic [63:0] mem_addr;
	logic [63:0] mem_wdata;
	logic [63:0] mem_rdata;
	logic        mem_ready;
	logic        commit_valid;
	logic [63:0] commit_pc;
	logic        commit_regwrite;
	logic [4:0]  commit_dst;
	logic [63:0] commit_data;

	entry_t      prog [$];
	logic [63:0] mem [logic [63:0]];  // Keyed by 8-byte aligned address
	logic [63:0] store_addrs [$];
	logic [63:0] store_datas [$];
	int          stores_seen = 0;

	soc_top #(
		.reset_pc (reset_pc)
	) i_dut (
		.clk,
		.reset,
		.mem_req,
		.mem_we,
		.mem_addr,
		.mem_wdata,
		.mem_rdata,
		.mem_ready,
		.commit_valid,
		.commit_pc,
		.commit_regwrite,
		.commit_dst,
		.commit_data
	);

	always #10 clk = ~clk;

	// ==============================
	// Instruction encoding
	// ==============================
	function automatic logic [31:0] imm_instr(input int opc, input int rd, input int f3,
		input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
	endfunction

	function automatic logic [31:0] reg_instr(input int f7, input int rs2, input int rs1,
		input int f3, input int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] store_instr(input int rs2, input int rs1, input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b011, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] upper_instr(input int rd, input int imm20);
		return {imm20[19:0], rd[4:0], 7'b0110111};
	endfunction

	task automatic stop_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped on first error");
	endtask

	task automatic compare(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			$display("Mismatch at %0t ns: %s expected %h, actual %h", $time, name, expected,
				actual);
			stop_run();
		end
	endtask

	task automatic add_entry(input logic [31:0] instr, input logic regwrite, input int dst,
		input logic [63:0] data);
		entry_t e;
		e.instr = instr;
		e.regwrite = regwrite;
		e.dst = dst[4:0];
		e.data = data;
		prog.push_back(e);
	endtask

	// ==============================
	// Program and expected commits
	// ==============================
	task automatic build_table();
		add_entry(imm_instr(opc_imm, 1, 0, 0, 5), 1'b1, 1, 64'd5);
		add_entry(imm_instr(opc_imm, 2, 0, 0, -3), 1'b1, 2, 64'hFFFF_FFFF_FFFF_FFFD);
		add_entry(upper_instr(5, 'h80001), 1'b1, 5, data_base);
		add_entry(imm_instr(opc_imm, 3, 0, 0, 'h6E), 1'b1, 3, 64'h6E);
		add_entry(imm_instr(opc_imm, 12, 0, 0, 'h123), 1'b1, 12, 64'h123);
		add_entry(reg_instr(0, 2, 1, 0, 6), 1'b1, 6, 64'd2);          // add x6, x1, x2
		add_entry(reg_instr('h20, 2, 1, 0, 7), 1'b1, 7, 64'd8);       // sub x7, x1, x2
		add_entry(imm_instr(opc_load, 10, 3, 5, 8), 1'b1, 10, 64'h0123_4567_89AB_CDEF);
		add_entry(reg_instr(0, 1, 3, 4, 9), 1'b1, 9, 64'h6B);         // xor
		add_entry(reg_instr(0, 2, 3, 7, 8), 1'b1, 8, 64'h6C);         // and
		add_entry(reg_instr(0, 7, 6, 6, 11), 1'b1, 11, 64'hA);        // or
		add_entry(imm_instr(opc_imm, 0, 0, 1, 7), 1'b1, 0, 64'd0);    // Write to x0
		add_entry(store_instr(2, 5, 16), 1'b0, 0, 64'd0);             // sd x2, 16(x5)
		add_entry(imm_instr(opc_load, 13, 3, 5, 16), 1'b1, 13, 64'hFFFF_FFFF_FFFF_FFFD);
		add_entry(imm_instr(opc_imm, 15, 0, 10, 1), 1'b1, 15, 64'h0123_4567_89AB_CDF0);
		add_entry(reg_instr(0, 9, 0, 6, 14), 1'b1, 14, 64'h6B);       // Reads x0
		add_entry(reg_instr('h20, 11, 12, 0, 16), 1'b1, 16, 64'h119);
		add_entry(reg_instr(0, 1, 13, 4, 17), 1'b1, 17, 64'hFFFF_FFFF_FFFF_FFF8);
		store_addrs.push_back(data_base + 64'd16);
		store_datas.push_back(64'hFFFF_FFFF_FFFF_FFFD);
	endtask

	task automatic load_memory();
		logic [63:0] addr;
		logic [63:0] word_addr;
		logic [63:0] word;
		for (int n = 0; n < prog.size(); n++) begin
			addr = reset_pc + 64'(4 * n);
			word_addr = {addr[63:3], 3'b000};
			word = mem.exists(word_addr) ? mem[word_addr] : 64'd0;
			if (addr[2])
				word[63:32] = prog[n].instr;
			else
				word[31:0] = prog[n].instr;
			mem[word_addr] = word;
		end
		mem[data_base + 64'd8] = 64'h0123_4567_89AB_CDEF;
		mem[data_base + 64'd16] = 64'h5555_AAAA_5555_AAAA; // Overwritten by sd
	endtask

	task automatic write_word();
		if (stores_seen >= store_addrs.size()) begin
			$display("Unexpected store to address %h", mem_addr);
			stop_run();
		end else begin
			compare("mem_addr", store_addrs[stores_seen], mem_addr);
			compare("mem_wdata", store_datas[stores_seen], mem_wdata);
			mem[mem_addr] = mem_wdata;
			stores_seen++;
		end
	endtask

	task automatic wait_commit(input int idx);
		int cycles;
		cycles = 0;
		@(posedge clk);
		while (commit_valid !== 1'b1) begin
			if (cycles == commit_timeout) begin
				$display("No commit for instruction %0d within %0d cycles", idx,
					commit_timeout);
				stop_run();
			end else begin
				cycles++;
				@(posedge clk);
			end
		end
	endtask

	// ==============================
	// Memory model
	// ==============================
	initial begin : mem_model
		int unsigned delay;
		bit          seen_req;
		bit          seen_ready;
		seen_req = 1'b0;
		seen_ready = 1'b0;
		mem_ready = 1'b0;
		mem_rdata = '0;
		void'($urandom(32'h5d6b));
		forever begin
			@(negedge clk);
			mem_ready = 1'b0;
			if (!reset && !seen_ready)
				compare("commit_valid", 64'd0, 64'(commit_valid));
			if (!reset && mem_req) begin
				if (!seen_req) begin
					compare("mem_we", 64'd0, 64'(mem_we)); // First access is a fetch
					compare("mem_addr", reset_pc, mem_addr);
					seen_req = 1'b1;
				end
				delay = $urandom % 4;
				repeat (delay) @(negedge clk);
				if (mem_we)
					write_word();
				else
					mem_rdata = mem.exists(mem_addr) ? mem[mem_addr] : 64'd0;
				mem_ready = 1'b1;
				seen_ready = 1'b1;
			end
		end
	end

	initial begin
		reset = 1'b1;
		build_table();
		load_memory();
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int n = 0; n < prog.size(); n++) begin
			wait_commit(n);
			compare("commit_pc", reset_pc + 64'(4 * n), commit_pc);
			compare("commit_regwrite", 64'(prog[n].regwrite), 64'(commit_regwrite));
			if (prog[n].regwrite)
				compare("commit_dst", 64'(prog[n].dst), 64'(commit_dst));
			if (prog[n].regwrite && prog[n].dst != 5'd0)
				compare("commit_data", prog[n].data, commit_data);
		end
		if (stores_seen == store_addrs.size()) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			$display("Expected %0d stores but saw %0d", store_addrs.size(), stores_seen);
			stop_run();
		end
	end

endmodule

//--- sources.f
src/core_pkg.sv
src/mem_bus_if.sv
src/regfile.sv
src/decoder.sv
src/execute.sv
src/core.sv
src/mem_arbiter.sv
src/soc_top.sv
sim/tb_soc.sv

//--- src/core.sv
module core #(
	parameter core_pkg::addr_t reset_pc = 64'h8000_0000
) (
	input  logic               clk,
	input  logic               reset,
	mem_bus_if.master          ibus,
	mem_bus_if.master          dbus,
	output logic               commit_valid,
	output core_pkg::addr_t    commit_pc,
	output logic               commit_regwrite,
	output core_pkg::reg_idx_t commit_dst,
	output core_pkg::word_t    commit_data
);
	import core_pkg::*;

	addr_t       pc;
	logic        fetch_on;
	logic        i_done, d_done;
	logic        fetch_ok, mem_ok, mem_access, advance;
	logic [31:0] fetch_word, ibuf;
	word_t       load_q, load_val;
	logic        f_valid;
	addr_t       f_pc;
	instr_t      f_instr;
	dec_data_t   dec_next, d_reg;
	ex_data_t    ex_next, e_reg;
	wb_data_t    wb_next, w_reg;

	// ==============================
	// Fetch port
	// ==============================
	assign ibus.req   = fetch_on && !i_done;
	assign ibus.we    = 1'b0;
	assign ibus.addr  = {pc[63:3], 3'b000};
	assign ibus.wdata = '0;

	assign fetch_word = i_done ? ibuf : (pc[2] ? ibus.rdata[63:32] : ibus.rdata[31:0]);
	assign fetch_ok   = i_done || ibus.ready;

	// ==============================
	// Data port, memory stage
	// ==============================
	assign mem_access = e_reg.valid && (e_reg.ctl.memread || e_reg.ctl.memwrite);
	assign dbus.req   = mem_access && !d_done;
	assign dbus.we    = e_reg.ctl.memwrite;
	assign dbus.addr  = {e_reg.result[63:3], 3'b000};
	assign dbus.wdata = e_reg.store_data;

	assign mem_ok   = !mem_access || d_done || dbus.ready;
	assign load_val = d_done ? load_q : dbus.rdata;

	assign advance = fetch_ok && mem_ok; // Whole pipe moves together

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= reset_pc;
			fetch_on <= 1'b0;
			i_done <= 1'b0;
			d_done <= 1'b0;
		end else begin
			fetch_on <= 1'b1;
			if (advance) begin
				pc <= pc + 64'd4;
				i_done <= 1'b0;
				d_done <= 1'b0;
			end else begin
				if (ibus.ready)
					i_done <= 1'b1; // Fetch finished early, park it
				if (dbus.ready)
					d_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ibus.ready)
			ibuf <= fetch_word;
		if (dbus.ready)
			load_q <= dbus.rdata;
	end

	// ==============================
	// Stage registers
	// ==============================
	decoder i_decoder (
		.clk,
		.reset,
		.instr (f_instr),
		.pc    (f_pc),
		.valid (f_valid),
		.wen   (commit_valid && w_reg.regwrite),
		.wa    (w_reg.dst),
		.wd    (w_reg.wdata),
		.dec   (dec_next)
	);

	execute i_execute (
		.dec (d_reg),
		.ex  (ex_next)
	);

	assign wb_next = '{
		valid:    e_reg.valid,
		pc:       e_reg.pc,
		regwrite: e_reg.ctl.regwrite,
		dst:      e_reg.dst,
		wdata:    e_reg.ctl.memread ? load_val : e_reg.result
	};

	always_ff @(posedge clk) begin
		if (reset) begin
			f_valid <= 1'b0;
			d_reg.valid <= 1'b0;
			e_reg.valid <= 1'b0;
			w_reg.valid <= 1'b0;
		end else if (advance) begin
			f_valid <= 1'b1;
			f_pc <= pc;
			f_instr <= fetch_word;
			d_reg <= dec_next;
			e_reg <= ex_next;
			w_reg <= wb_next;
		end
	end

	// Retire as the writeback slot is vacated
	assign commit_valid    = advance && w_reg.valid;
	assign commit_pc       = w_reg.pc;
	assign commit_regwrite = w_reg.regwrite;
	assign commit_dst      = w_reg.dst;
	assign commit_data     = w_reg.wdata;

endmodule

//--- src/core_pkg.sv
package core_pkg;

	typedef logic [63:0] word_t;
	typedef logic [63:0] addr_t;
	typedef logic [4:0]  reg_idx_t;

	typedef enum logic [6:0] {
		op_imm = 7'b0010011,
		op     = 7'b0110011,
		lui    = 7'b0110111,
		load   = 7'b0000011,
		store  = 7'b0100011
	} opcode_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_pass_b
	} alu_op_e;

	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		reg_idx_t   rd;
		opcode_e    opcode;
	} r_fields_t;

	// imm_lo sits where rd is in the R view
	typedef struct packed {
		logic [6:0] imm_hi;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		opcode_e    opcode;
	} is_fields_t;

	typedef union packed {
		r_fields_t  r;
		is_fields_t i;
	} instr_t;

	typedef struct packed {
		logic    regwrite;
		logic    memread;
		logic    memwrite;
		logic    alu_src_imm;
		alu_op_e alu_op;
	} ctl_t;

	typedef struct packed {
		logic     valid;
		addr_t    pc;
		ctl_t     ctl;
		reg_idx_t dst;
		word_t    rs1_val;
		word_t    rs2_val;
		word_t    imm;
	} dec_data_t;

	typedef struct packed {
		logic     valid;
		addr_t    pc;
		ctl_t     ctl;
		reg_idx_t dst;
		word_t    result;    // ALU out or memory address
		word_t    store_data;
	} ex_data_t;

	typedef struct packed {
		logic     valid;
		addr_t    pc;
		logic     regwrite;
		reg_idx_t dst;
		word_t    wdata;
	} wb_data_t;

endpackage

//--- src/decoder.sv
module decoder (
	input  logic                clk,
	input  logic                reset,
	input  core_pkg::instr_t    instr,
	input  core_pkg::addr_t     pc,
	input  logic                valid,
	input  logic                wen,
	input  core_pkg::reg_idx_t  wa,
	input  core_pkg::word_t     wd,
	output core_pkg::dec_data_t dec
);
	import core_pkg::*;

	word_t   rs1_val, rs2_val;
	word_t   i_imm, s_imm, u_imm;
	alu_op_e f3_op;
	logic    f3_ok;
	logic    known;

	regfile i_regfile (
		.clk,
		.reset,
		.ra1 (instr.r.rs1),
		.ra2 (instr.r.rs2),
		.rd1 (rs1_val),
		.rd2 (rs2_val),
		.wen,
		.wa,
		.wd
	);

	assign i_imm = {{52{instr.i.imm_hi[6]}}, instr.i.imm_hi, instr.i.rs2};
	assign s_imm = {{52{instr.i.imm_hi[6]}}, instr.i.imm_hi, instr.i.imm_lo};
	assign u_imm = {{32{instr.i.imm_hi[6]}}, instr.i.imm_hi, instr.i.rs2,
		instr.i.rs1, instr.i.funct3, 12'h000};

	always_comb begin
		f3_ok = 1'b1;
		case (instr.r.funct3)
			3'b000: f3_op = (instr.r.opcode == op && instr.r.funct7[5]) ? alu_sub : alu_add;
			3'b100: f3_op = alu_xor;
			3'b110: f3_op = alu_or;
			3'b111: f3_op = alu_and;
			default: begin
				f3_op = alu_add;
				f3_ok = 1'b0;
			end
		endcase
	end

	always_comb begin
		dec = '0;
		known = 1'b1;
		dec.pc = pc;
		dec.dst = instr.r.rd;
		dec.rs1_val = rs1_val;
		dec.rs2_val = rs2_val;
		case (instr.r.opcode)
			op_imm: begin
				dec.ctl = '{1'b1, 1'b0, 1'b0, 1'b1, f3_op};
				dec.imm = i_imm;
				known = f3_ok;
			end
			op: begin
				dec.ctl = '{1'b1, 1'b0, 1'b0, 1'b0, f3_op};
				known = f3_ok;
			end
			lui: begin
				dec.ctl = '{1'b1, 1'b0, 1'b0, 1'b1, alu_pass_b};
				dec.imm = u_imm;
			end
			load: begin
				dec.ctl = '{1'b1, 1'b1, 1'b0, 1'b1, alu_add};
				dec.imm = i_imm;
				known = (instr.r.funct3 == 3'b011); // ld only
			end
			store: begin
				dec.ctl = '{1'b0, 1'b0, 1'b1, 1'b1, alu_add};
				dec.imm = s_imm;
				known = (instr.r.funct3 == 3'b011); // sd only
			end
			default: known = 1'b0;
		endcase
		dec.valid = valid && known;
	end

endmodule

//--- src/execute.sv
module execute (
	input  core_pkg::dec_data_t dec,
	output core_pkg::ex_data_t  ex
);
	import core_pkg::*;

	word_t opnd_b;
	word_t alu_out;

	assign opnd_b = dec.ctl.alu_src_imm ? dec.imm : dec.rs2_val;

	// Loads and stores use alu_add for the address
	always_comb begin
		case (dec.ctl.alu_op)
			alu_add:    alu_out = dec.rs1_val + opnd_b;
			alu_sub:    alu_out = dec.rs1_val - opnd_b;
			alu_and:    alu_out = dec.rs1_val & opnd_b;
			alu_or:     alu_out = dec.rs1_val | opnd_b;
			alu_xor:    alu_out = dec.rs1_val ^ opnd_b;
			alu_pass_b: alu_out = opnd_b;   // lui
			default:    alu_out = '0;
		endcase
	end

	assign ex = '{
		valid:      dec.valid,
		pc:         dec.pc,
		ctl:        dec.ctl,
		dst:        dec.dst,
		result:     alu_out,
		store_data: dec.rs2_val
	};

endmodule

//--- src/mem_arbiter.sv
module mem_arbiter (
	input  logic            clk,
	input  logic            reset,
	mem_bus_if.slave        ibus,
	mem_bus_if.slave        dbus,
	output logic            mem_req,
	output logic            mem_we,
	output core_pkg::addr_t mem_addr,
	output core_pkg::word_t mem_wdata,
	input  core_pkg::word_t mem_rdata,
	input  logic            mem_ready
);

	logic busy;
	logic owner_d;  // 1 = data port holds the bus
	logic sel_d;

	// Data wins when idle
	assign sel_d = busy ? owner_d : dbus.req;

	assign mem_req   = sel_d ? dbus.req   : ibus.req;
	assign mem_we    = sel_d ? dbus.we    : ibus.we;
	assign mem_addr  = sel_d ? dbus.addr  : ibus.addr;
	assign mem_wdata = sel_d ? dbus.wdata : ibus.wdata;

	assign dbus.ready = mem_ready && sel_d;
	assign ibus.ready = mem_ready && !sel_d;
	assign dbus.rdata = sel_d ? mem_rdata : '0;
	assign ibus.rdata = sel_d ? '0 : mem_rdata;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			owner_d <= 1'b0;
		end else if (mem_ready) begin
			busy <= 1'b0;
		end else if (mem_req && !busy) begin
			busy <= 1'b1; // Lock grant until ready
			owner_d <= sel_d;
		end
	end

endmodule

//--- src/mem_bus_if.sv
interface mem_bus_if;
	import core_pkg::*;

	logic  req;     // Level, held until ready
	logic  we;
	addr_t addr;    // 8-byte aligned
	word_t wdata;
	word_t rdata;   // Valid with ready
	logic  ready;   // One-cycle pulse

	modport master (
		output req, we, addr, wdata,
		input  rdata, ready
	);

	modport slave (
		input  req, we, addr, wdata,
		output rdata, ready
	);

endinterface

//--- src/regfile.sv
module regfile (
	input  logic              clk,
	input  logic              reset,
	input  core_pkg::reg_idx_t ra1,
	input  core_pkg::reg_idx_t ra2,
	output core_pkg::word_t   rd1,
	output core_pkg::word_t   rd2,
	input  logic              wen,
	input  core_pkg::reg_idx_t wa,
	input  core_pkg::word_t   wd
);
	import core_pkg::*;

	word_t regs [32];
	logic  wr_live;

	assign wr_live = wen && (wa != '0); // x0 stays zero

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int k = 0; k < 32; k++) begin
				regs[k] <= '0;
			end
		end else if (wr_live) begin
			regs[wa] <= wd;
		end
	end

	// Same-cycle write bypass
	assign rd1 = (wr_live && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (wr_live && wa == ra2) ? wd : regs[ra2];

endmodule

//--- src/soc_top.sv
module soc_top #(
	parameter core_pkg::addr_t reset_pc = 64'h8000_0000
) (
	input  logic               clk,
	input  logic               reset,
	output logic               mem_req,
	output logic               mem_we,
	output core_pkg::addr_t    mem_addr,
	output core_pkg::word_t    mem_wdata,
	input  core_pkg::word_t    mem_rdata,
	input  logic               mem_ready,
	output logic               commit_valid,
	output core_pkg::addr_t    commit_pc,
	output logic               commit_regwrite,
	output core_pkg::reg_idx_t commit_dst,
	output core_pkg::word_t    commit_data
);

	mem_bus_if ibus ();
	mem_bus_if dbus ();

	core #(
		.reset_pc (reset_pc)
	) i_core (
		.clk,
		.reset,
		.ibus,
		.dbus,
		.commit_valid,
		.commit_pc,
		.commit_regwrite,
		.commit_dst,
		.commit_data
	);

	mem_arbiter i_arbiter (
		.clk,
		.reset,
		.ibus,
		.dbus,
		.mem_req,
		.mem_we,
		.mem_addr,
		.mem_wdata,
		.mem_rdata,
		.mem_ready
	);

endmodule
